//--- hw/jtag_data_regs.sv
//--------------------
// data registers
// bypass, idcode and user scan chains plus the user update port
//--------------------
`timescale 1ns/1ps

module jtag_data_regs import jtag_pkg::*; (
    input  logic                  tck,
    input  logic                  trst_n,
    input  tap_ctrl_t             ctrl,
    input  instr_e                instr,
    input  logic                  tdi,
    input  logic [USER_WIDTH-1:0] user_status,
    output logic                  dr_so,
    output logic                  upd_valid,
    input  logic                  upd_ready,
    output logic [USER_WIDTH-1:0] upd_data
);

    logic                  bypass_bit;
    logic [31:0]           idcode_sr;
    logic [USER_WIDTH-1:0] user_sr;
    logic                  upd_load;

    //--------------------
    // scan chains
    //--------------------
    // only the chain picked by instr moves
    always_ff @(posedge tck) begin
        case (instr)
            idcode_op: begin
                if (ctrl.capture_dr) begin
                    idcode_sr <= IDCODE_VALUE;
                end else if (ctrl.shift_dr) begin
                    idcode_sr <= {tdi, idcode_sr[31:1]};
                end
            end
            user_op: begin
                if (ctrl.capture_dr) begin
                    user_sr <= user_status;
                end else if (ctrl.shift_dr) begin
                    user_sr <= {tdi, user_sr[USER_WIDTH-1:1]};
                end
            end
            default: begin
                if (ctrl.capture_dr) begin
                    bypass_bit <= 1'b0;
                end else if (ctrl.shift_dr) begin
                    bypass_bit <= tdi;
                end
            end
        endcase
    end

    always_comb begin
        case (instr)
            idcode_op: dr_so = idcode_sr[0];
            user_op:   dr_so = user_sr[0];
            default:   dr_so = bypass_bit;
        endcase
    end

    //--------------------
    // update port
    //--------------------
    assign upd_load = ctrl.update_dr && (instr == user_op);

    // holding word, a newer update overwrites a pending one
    always_ff @(posedge tck) begin
        if (upd_load) begin
            upd_data <= user_sr;
        end
    end

    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            upd_valid <= 1'b0;
        end else if (upd_load) begin
            upd_valid <= 1'b1;
        end else if (upd_ready) begin
            upd_valid <= 1'b0;
        end
    end

    // an offered word must be fully known
    a_upd_known: assert property (
        @(posedge tck) disable iff (!trst_n)
        upd_valid |-> !$isunknown(upd_data)
    ) else $error("upd_data unknown while upd_valid is high");

endmodule

//--- hw/jtag_instr_reg.sv
//--------------------
// instruction register
// 4-bit shifter plus update latch holding the active opcode
//--------------------
`timescale 1ns/1ps

module jtag_instr_reg import jtag_pkg::*; (
    input  logic      tck,
    input  logic      trst_n,
    input  tap_ctrl_t ctrl,
    input  logic      tdi,
    output instr_e    instr,
    output logic      ir_so
);

    logic [IR_WIDTH-1:0] ir_shift;

    // shifter, tdi enters at the msb
    always_ff @(posedge tck) begin
        if (ctrl.capture_ir) begin
            ir_shift <= IR_CAPTURE;
        end else if (ctrl.shift_ir) begin
            ir_shift <= {tdi, ir_shift[IR_WIDTH-1:1]};
        end
    end

    assign ir_so = ir_shift[0];

    //--------------------
    // update latch
    //--------------------
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            instr <= idcode_op;
        end else if (ctrl.tlr) begin
            instr <= idcode_op;
        end else if (ctrl.update_ir) begin
            // undefined codes fold onto bypass here
            case (ir_shift)
                idcode_op: instr <= idcode_op;
                user_op:   instr <= user_op;
                default:   instr <= bypass_op;
            endcase
        end
    end

endmodule

//--- hw/jtag_pkg.sv
//--------------------
// jtag tap shared definitions
// state and opcode enums, controller strobes, device constants
//--------------------
package jtag_pkg;

    //--------------------
    // tap controller states, standard encoding order
    //--------------------
    typedef enum logic [3:0] {
        test_logic_reset = 4'h0,
        run_test_idle    = 4'h1,
        select_dr_scan   = 4'h2,
        capture_dr       = 4'h3,
        shift_dr         = 4'h4,
        exit1_dr         = 4'h5,
        pause_dr         = 4'h6,
        exit2_dr         = 4'h7,
        update_dr        = 4'h8,
        select_ir_scan   = 4'h9,
        capture_ir       = 4'hA,
        shift_ir         = 4'hB,
        exit1_ir         = 4'hC,
        pause_ir         = 4'hD,
        exit2_ir         = 4'hE,
        update_ir        = 4'hF
    } tap_state_e;

    // active instructions, any other code acts as bypass
    typedef enum logic [3:0] {
        idcode_op = 4'd1,
        user_op   = 4'd2,
        bypass_op = 4'd15
    } instr_e;

    // one-hot style strobes decoded from the controller state
    typedef struct packed {
        logic tlr;
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
        logic capture_ir;
        logic shift_ir;
        logic update_ir;
    } tap_ctrl_t;

    localparam int          IR_WIDTH     = 4;
    localparam logic [3:0]  IR_CAPTURE   = 4'b0001;
    // lsb must be 1 per the standard
    localparam logic [31:0] IDCODE_VALUE = 32'h1B5A_C0DF;
    localparam int          USER_WIDTH   = 16;

endpackage

//--- hw/jtag_tap_fsm.sv
//--------------------
// tap controller
// steps the 16-state machine on tms, decodes the strobes
//--------------------
`timescale 1ns/1ps

module jtag_tap_fsm import jtag_pkg::*; (
    input  logic      tck,
    input  logic      trst_n,
    input  logic      tms,
    output tap_ctrl_t ctrl
);

    tap_state_e state;
    tap_state_e next_state;

    //--------------------
    // state register
    //--------------------
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            state <= test_logic_reset;
        end else begin
            state <= next_state;
        end
    end

    //--------------------
    // next state
    //--------------------
    always_comb begin
        next_state = state;
        case (state)
            test_logic_reset: next_state = tms ? test_logic_reset : run_test_idle;
            run_test_idle:    next_state = tms ? select_dr_scan : run_test_idle;
            select_dr_scan:   next_state = tms ? select_ir_scan : capture_dr;
            capture_dr:       next_state = tms ? exit1_dr : shift_dr;
            shift_dr:         next_state = tms ? exit1_dr : shift_dr;
            exit1_dr:         next_state = tms ? update_dr : pause_dr;
            pause_dr:         next_state = tms ? exit2_dr : pause_dr;
            exit2_dr:         next_state = tms ? update_dr : shift_dr;
            update_dr:        next_state = tms ? select_dr_scan : run_test_idle;
            select_ir_scan:   next_state = tms ? test_logic_reset : capture_ir;
            capture_ir:       next_state = tms ? exit1_ir : shift_ir;
            shift_ir:         next_state = tms ? exit1_ir : shift_ir;
            exit1_ir:         next_state = tms ? update_ir : pause_ir;
            pause_ir:         next_state = tms ? exit2_ir : pause_ir;
            exit2_ir:         next_state = tms ? update_ir : shift_ir;
            update_ir:        next_state = tms ? select_dr_scan : run_test_idle;
            default:          next_state = test_logic_reset;
        endcase
    end

    // strobes come straight from the registered state
    always_comb begin
        ctrl.tlr        = (state == test_logic_reset);
        ctrl.capture_dr = (state == capture_dr);
        ctrl.shift_dr   = (state == shift_dr);
        ctrl.update_dr  = (state == update_dr);
        ctrl.capture_ir = (state == capture_ir);
        ctrl.shift_ir   = (state == shift_ir);
        ctrl.update_ir  = (state == update_ir);
    end

    // state must stay known across every tck once out of reset
    a_state_known: assert property (
        @(posedge tck) disable iff (!trst_n)
        !$isunknown(state)
    ) else $error("tap state unknown");

endmodule

//--- hw/jtag_tap_top.sv
//--------------------
// jtag tap top level
// controller, instruction and data registers, tdo stage
//--------------------
`timescale 1ns/1ps

module jtag_tap_top import jtag_pkg::*; (
    input  logic                  tck,
    input  logic                  trst_n,
    input  logic                  tms,
    input  logic                  tdi,
    input  logic [USER_WIDTH-1:0] user_status,
    output logic                  tdo,
    output logic                  tdo_oe,
    output logic                  upd_valid,
    input  logic                  upd_ready,
    output logic [USER_WIDTH-1:0] upd_data
);

    tap_ctrl_t ctrl;
    instr_e    instr;
    logic      ir_so;
    logic      dr_so;

    jtag_tap_fsm fsm_i (
        .tck    (tck),
        .trst_n (trst_n),
        .tms    (tms),
        .ctrl   (ctrl)
    );

    jtag_instr_reg ir_i (
        .tck    (tck),
        .trst_n (trst_n),
        .ctrl   (ctrl),
        .tdi    (tdi),
        .instr  (instr),
        .ir_so  (ir_so)
    );

    jtag_data_regs dr_i (
        .tck         (tck),
        .trst_n      (trst_n),
        .ctrl        (ctrl),
        .instr       (instr),
        .tdi         (tdi),
        .user_status (user_status),
        .dr_so       (dr_so),
        .upd_valid   (upd_valid),
        .upd_ready   (upd_ready),
        .upd_data    (upd_data)
    );

    jtag_tdo_out tdo_i (
        .tck    (tck),
        .trst_n (trst_n),
        .ctrl   (ctrl),
        .ir_so  (ir_so),
        .dr_so  (dr_so),
        .tdo    (tdo),
        .tdo_oe (tdo_oe)
    );

endmodule

//--- hw/jtag_tdo_out.sv
//--------------------
// tdo output stage
// falling-edge flops for tdo and its enable
//--------------------
`timescale 1ns/1ps

module jtag_tdo_out import jtag_pkg::*; (
    input  logic      tck,
    input  logic      trst_n,
    input  tap_ctrl_t ctrl,
    input  logic      ir_so,
    input  logic      dr_so,
    output logic      tdo,
    output logic      tdo_oe
);

    logic tdo_next;

    // pick the serial source for the current shift state
    always_comb begin
        if (ctrl.shift_ir) begin
            tdo_next = ir_so;
        end else if (ctrl.shift_dr) begin
            tdo_next = dr_so;
        end else begin
            tdo_next = 1'b0;
        end
    end

    // negedge so the host samples a settled value on the rising edge
    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            tdo    <= 1'b0;
            tdo_oe <= 1'b0;
        end else begin
            tdo    <= tdo_next;
            tdo_oe <= ctrl.shift_dr || ctrl.shift_ir;
        end
    end

    // enabled tdo must carry a known bit from a captured chain
    a_oe_known: assert property (
        @(posedge tck) disable iff (!trst_n)
        tdo_oe |-> !$isunknown(tdo)
    ) else $error("tdo unknown while tdo_oe is high");

endmodule

//--- list.f
hw/jtag_pkg.sv
hw/jtag_tap_fsm.sv
hw/jtag_instr_reg.sv
hw/jtag_data_regs.sv
hw/jtag_tdo_out.sv
hw/jtag_tap_top.sv
verification/tb_clock.sv
verification/jtag_checker.sv
verification/jtag_tb.sv

//--- verification/jtag_checker.sv
//--------------------
// jtag tap checker
// reference model of the tap, compares tdo and the update port
//--------------------
`timescale 1ns/1ps

module jtag_checker import jtag_pkg::*; (
    input  logic                  tck,
    input  logic                  trst_n,
    input  logic                  tms,
    input  logic                  tdi,
    input  logic                  upd_ready,
    input  logic [USER_WIDTH-1:0] user_status,
    input  logic                  tdo,
    input  logic                  tdo_oe,
    input  logic                  upd_valid,
    input  logic [USER_WIDTH-1:0] upd_data,
    output int                    error_count
);

    typedef struct packed {
        tap_state_e            state;
        logic [3:0]            ir_sr;
        logic [3:0]            ir_hold;
        logic                  bypass;
        logic [31:0]           idcode_sr;
        logic [USER_WIDTH-1:0] user_sr;
        logic                  upd_valid;
        logic [USER_WIDTH-1:0] upd_data;
    } model_t;

    model_t m;
    int     errors = 0;
    int     test_errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    assign error_count = errors;

    //--------------------
    // reference model
    //--------------------
    function automatic tap_state_e next_state(tap_state_e s, logic t);
        case (s)
            test_logic_reset: return t ? test_logic_reset : run_test_idle;
            run_test_idle:    return t ? select_dr_scan : run_test_idle;
            select_dr_scan:   return t ? select_ir_scan : capture_dr;
            capture_dr:       return t ? exit1_dr : shift_dr;
            shift_dr:         return t ? exit1_dr : shift_dr;
            exit1_dr:         return t ? update_dr : pause_dr;
            pause_dr:         return t ? exit2_dr : pause_dr;
            exit2_dr:         return t ? update_dr : shift_dr;
            update_dr:        return t ? select_dr_scan : run_test_idle;
            select_ir_scan:   return t ? test_logic_reset : capture_ir;
            capture_ir:       return t ? exit1_ir : shift_ir;
            shift_ir:         return t ? exit1_ir : shift_ir;
            exit1_ir:         return t ? update_ir : pause_ir;
            pause_ir:         return t ? exit2_ir : pause_ir;
            exit2_ir:         return t ? update_ir : shift_ir;
            default:          return t ? select_dr_scan : run_test_idle;
        endcase
    endfunction

    // ir_hold keeps the raw code, folding to bypass happens on use
    function automatic logic [3:0] active_op(logic [3:0] raw);
        return (raw == idcode_op || raw == user_op) ? raw : bypass_op;
    endfunction

    function automatic logic serial_out(model_t s);
        if (s.state == shift_ir) begin
            return s.ir_sr[0];
        end
        if (s.state != shift_dr) begin
            return 1'b0;
        end
        case (active_op(s.ir_hold))
            idcode_op: return s.idcode_sr[0];
            user_op:   return s.user_sr[0];
            default:   return s.bypass;
        endcase
    endfunction

    function automatic model_t step_model(model_t s, logic t, logic d, logic ready,
                                          logic [USER_WIDTH-1:0] status);
        model_t     n;
        logic [3:0] op;
        n = s;
        op = active_op(s.ir_hold);
        n.state = next_state(s.state, t);
        case (s.state)
            test_logic_reset: n.ir_hold = idcode_op;
            capture_ir:       n.ir_sr = IR_CAPTURE;
            shift_ir:         n.ir_sr = {d, s.ir_sr[3:1]};
            update_ir:        n.ir_hold = s.ir_sr;
            capture_dr: begin
                if (op == idcode_op) n.idcode_sr = IDCODE_VALUE;
                else if (op == user_op) n.user_sr = status;
                else n.bypass = 1'b0;
            end
            shift_dr: begin
                if (op == idcode_op) n.idcode_sr = {d, s.idcode_sr[31:1]};
                else if (op == user_op) n.user_sr = {d, s.user_sr[USER_WIDTH-1:1]};
                else n.bypass = d;
            end
            default: ;
        endcase
        // a new word wins over a pending transfer
        if (s.state == update_dr && op == user_op) begin
            n.upd_valid = 1'b1;
            n.upd_data  = s.user_sr;
        end else if (ready) begin
            n.upd_valid = 1'b0;
        end
        return n;
    endfunction

    function automatic model_t reset_model();
        model_t r;
        r = '0;
        r.state   = test_logic_reset;
        r.ir_hold = idcode_op;
        return r;
    endfunction

    //--------------------
    // comparison
    //--------------------
    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            $display("error at %0t: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    // tdo settled at the falling edge, so it is read at the rising edge
    always @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            m <= reset_model();
        end else begin
            check_value("tdo_oe", (m.state == shift_dr || m.state == shift_ir), tdo_oe);
            check_value("tdo", serial_out(m), tdo);
            m <= step_model(m, tms, tdi, upd_ready, user_status);
        end
    end

    // update port moves on the rising edge, read it half a cycle later
    always @(negedge tck) begin
        if (trst_n) begin
            check_value("upd_valid", m.upd_valid, upd_valid);
            if (m.upd_valid) begin
                check_value("upd_data", m.upd_data, upd_data);
            end
        end
    end

    task automatic close_test(string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s (%0d mismatches)", tests_run, name,
                 (test_errors == 0) ? "ok" : "FAILED", test_errors);
        test_errors = 0;
    endtask

    task automatic print_counts();
        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, errors);
    endtask

endmodule

//--- verification/jtag_tb.sv
//--------------------
// jtag tap testbench
// tms/tdi sequences, update-port ready driver and run limit
//--------------------
`timescale 1ns/1ps

module jtag_tb import jtag_pkg::*; ();

    // rough cycles per test, with the idle cycles between them
    localparam int TEST_CYCLES = 45 + 60 + 55 + 80 + 410;
    localparam int TIMEOUT     = 4 + TEST_CYCLES + TEST_CYCLES / 2;

    logic                  tck;
    logic                  trst_n;
    logic                  tms;
    logic                  tdi;
    logic                  upd_ready;
    logic                  hold_ready;
    logic [USER_WIDTH-1:0] user_status;
    logic                  tdo;
    logic                  tdo_oe;
    logic                  upd_valid;
    logic [USER_WIDTH-1:0] upd_data;
    int                    error_count;
    int                    cycles;
    int unsigned           seed;

    tb_clock clk_i (.tck(tck), .trst_n(trst_n));

    jtag_tap_top dut_i (
        .tck         (tck),
        .trst_n      (trst_n),
        .tms         (tms),
        .tdi         (tdi),
        .user_status (user_status),
        .tdo         (tdo),
        .tdo_oe      (tdo_oe),
        .upd_valid   (upd_valid),
        .upd_ready   (upd_ready),
        .upd_data    (upd_data)
    );

    jtag_checker chk_i (
        .tck         (tck),
        .trst_n      (trst_n),
        .tms         (tms),
        .tdi         (tdi),
        .upd_ready   (upd_ready),
        .user_status (user_status),
        .tdo         (tdo),
        .tdo_oe      (tdo_oe),
        .upd_valid   (upd_valid),
        .upd_data    (upd_data),
        .error_count (error_count)
    );

    //--------------------
    // sequence tasks
    //--------------------
    task automatic step(input logic tms_v, input logic tdi_v);
        @(posedge tck);
        #1;
        tms = tms_v;
        tdi = tdi_v;
    endtask

    // full ir or dr scan from run_test_idle back to run_test_idle
    task automatic scan(input logic is_ir, input logic [31:0] bits, input int n);
        step(1'b1, 1'b0);
        if (is_ir) begin
            step(1'b1, 1'b0);
        end
        step(1'b0, 1'b0);
        step(1'b0, 1'b0);
        for (int i = 0; i < n; i++) begin
            step(i == n - 1, bits[i]);
        end
        step(1'b1, 1'b0);
        step(1'b0, 1'b0);
    endtask

    task automatic tms_reset();
        repeat (5) step(1'b1, 1'b0);
        step(1'b0, 1'b0);
    endtask

    task automatic end_test(input string name);
        repeat (2) @(negedge tck);
        #1;
        chk_i.close_test(name);
    endtask

    // ready toggles at random unless a test holds it low
    always @(posedge tck) begin
        #1;
        upd_ready = hold_ready ? 1'b0 : (($urandom % 2) == 1);
    end

    //--------------------
    // tests
    //--------------------
    initial begin
        tms         = 1'b1;
        tdi         = 1'b0;
        upd_ready   = 1'b0;
        hold_ready  = 1'b0;
        user_status = '0;
        seed        = $urandom(53054);
        @(posedge trst_n);

        step(1'b0, 1'b0);
        scan(1'b0, 32'h0, 32);
        end_test("idcode after reset");

        repeat (12) step(($urandom % 2) == 1, ($urandom % 2) == 1);
        tms_reset();
        scan(1'b0, 32'h0, 32);
        end_test("tms reset from random state");

        scan(1'b1, bypass_op, IR_WIDTH);
        scan(1'b0, $urandom, 8 + ($urandom % 24));
        end_test("bypass");

        user_status = $urandom;
        scan(1'b1, user_op, IR_WIDTH);
        hold_ready = 1'b1;
        scan(1'b0, $urandom, USER_WIDTH);
        repeat (6) step(1'b0, 1'b0);
        user_status = $urandom;
        scan(1'b0, $urandom, USER_WIDTH);
        repeat (6) step(1'b0, 1'b0);
        hold_ready = 1'b0;
        repeat (10) step(1'b0, 1'b0);
        end_test("user scan and update port");

        // tdi is random in shift_ir too, so undefined codes get loaded
        repeat (400) begin
            step(($urandom % 10) < 4, ($urandom % 2) == 1);
            if (($urandom % 16) == 0) begin
                user_status = $urandom;
            end
        end
        tms_reset();
        end_test("random walk");

        chk_i.print_counts();
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge tck);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- verification/tb_clock.sv
//--------------------
// testbench clock and reset
// 4 ns tck, trst_n held low for 4 cycles
//--------------------
`timescale 1ns/1ps

module tb_clock (
    output logic tck,
    output logic trst_n
);

    initial begin
        tck = 1'b0;
        forever #2 tck = ~tck;
    end

    initial begin
        trst_n = 1'b0;
        repeat (4) @(posedge tck);
        #1;
        trst_n = 1'b1;
    end

endmodule
